// ==== rtl/codecPkg.sv ====
// precision and alphabet constants, coder FSM encoding and shared symbol/frequency types
package codecPkg;

    // interval precision
    localparam int PRECISION = 32;
    localparam logic [PRECISION-1:0] WHOLE = 1 << (PRECISION - 1);
    localparam logic [PRECISION-1:0] HALF = 1 << (PRECISION - 2);
    localparam logic [PRECISION-1:0] QUARTER = 1 << (PRECISION - 3);
    localparam logic [PRECISION-1:0] THREE_QUARTERS = 3 << (PRECISION - 3);

    // alphabet: 16 data symbols, EOF last
    localparam int NUM_SYMBOLS = 17;
    localparam int EOF_SYMBOL = 16;
    localparam int SYMBOL_W = 5;
    localparam int FREQ_W = 11;
    localparam int INIT_COUNT = 64;    // equal start count for every symbol

    localparam int PRODUCT_W = PRECISION + FREQ_W;   // width times frequency
    localparam int PENDING_W = 7;
    localparam int WORD_W = 32;

    typedef enum logic [3:0] {
        IDLE,
        MUL,
        DIV_HIGH,          // b from freqEnd
        DIV_LOW,           // a from freqBegin
        RESCALE,
        EMIT_PENDING,
        REQUEST_SYMBOL,
        UPDATE_MODEL,
        TERMINATE,
        WAIT_PACKER        // last word still with the host
    } coderState_e;

    typedef logic [SYMBOL_W-1:0] symbol_t;
    typedef logic [FREQ_W-1:0] freq_t;

endpackage

// ==== rtl/codecIfs.sv ====
// divider, frequency model and bit packer buses between the coder and its helpers
`timescale 1ns/100ps

interface divIf;
    import codecPkg::*;

    logic go;                         // one-cycle request
    logic [PRODUCT_W-1:0] dividend;
    freq_t divisor;
    logic done;                       // one-cycle result strobe
    logic [PRECISION-1:0] quotient;

    modport coder (output go, dividend, divisor, input done, quotient);
    modport divider (input go, dividend, divisor, output done, quotient);
endinterface

interface modelIf;
    import codecPkg::*;

    logic init;
    logic update;
    symbol_t symbol;
    freq_t freqBegin;   // table reads for symbol
    freq_t freqEnd;
    freq_t total;

    modport coder (output init, update, symbol, input freqBegin, freqEnd, total);
    modport model (input init, update, symbol, output freqBegin, freqEnd, total);
endinterface

interface packIf;
    logic bitValid;
    logic bitValue;
    logic flush;    // close the partial word
    logic full;     // word waiting for the host

    modport coder (output bitValid, bitValue, flush, input full);
    modport packer (input bitValid, bitValue, flush, output full);
endinterface

// ==== rtl/freqModel.sv ====
// adaptive cumulative frequency table with uniform init and decrement update
`timescale 1ns/100ps

module freqModel (
    input logic clk,
    input logic rstn,
    modelIf.model model
);
    import codecPkg::*;

    freq_t freqBegin [NUM_SYMBOLS];
    freq_t freqEnd [NUM_SYMBOLS];
    freq_t total;

    // symbol k covers INIT_COUNT*k up to INIT_COUNT*(k+1)
    always_ff @(posedge clk) begin
        if (!rstn || model.init) begin
            for (int i = 0; i < NUM_SYMBOLS; i++) begin
                freqBegin[i] <= freq_t'(INIT_COUNT * i);
                freqEnd[i] <= freq_t'(INIT_COUNT * (i + 1));
            end
            total <= freq_t'(INIT_COUNT * NUM_SYMBOLS);
        end else if (model.update) begin
            for (int i = 0; i < NUM_SYMBOLS; i++) begin
                if (i >= int'(model.symbol)) begin
                    freqEnd[i] <= freqEnd[i] - 1'b1;
                end
                if (i > int'(model.symbol)) begin    // lower symbols keep their begin
                    freqBegin[i] <= freqBegin[i] - 1'b1;
                end
            end
            total <= total - 1'b1;
        end
    end

    assign model.freqBegin = freqBegin[model.symbol];
    assign model.freqEnd = freqEnd[model.symbol];
    assign model.total = total;

    // EOF is coded once at the end and never adapts the table
    assert property (@(posedge clk) disable iff (!rstn)
        model.update |-> model.symbol != EOF_SYMBOL)
        else $error("model update requested for EOF");

endmodule

// ==== rtl/intervalDivider.sv ====
// restoring shift-subtract divider for product over total, one quotient bit per cycle
`timescale 1ns/100ps

module intervalDivider (
    input logic clk,
    input logic rstn,
    divIf.divider div
);
    import codecPkg::*;

    logic busy;
    logic [$clog2(PRODUCT_W)-1:0] stepCount;
    logic [FREQ_W-1:0] rem;          // partial remainder
    logic [PRODUCT_W-1:0] quo;       // dividend shifts out, quotient shifts in
    freq_t divisor;
    logic [FREQ_W:0] trial;
    logic [FREQ_W:0] diff;

    assign trial = {rem, quo[PRODUCT_W-1]};
    assign diff = trial - {1'b0, divisor};
    assign div.quotient = quo[PRECISION-1:0];   // upper bits are zero as product <= w*total

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            stepCount <= '0;
            div.done <= 1'b0;
        end else begin
            div.done <= 1'b0;
            if (div.go) begin
                busy <= 1'b1;
                stepCount <= '0;
            end else if (busy) begin
                stepCount <= stepCount + 1'b1;
                if (stepCount == PRODUCT_W - 1) begin   // last quotient bit this cycle
                    busy <= 1'b0;
                    div.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div.go) begin
            rem <= '0;
            quo <= div.dividend;
            divisor <= div.divisor;
        end else if (busy) begin
            if (!diff[FREQ_W]) begin
                rem <= diff[FREQ_W-1:0];
                quo <= {quo[PRODUCT_W-2:0], 1'b1};
            end else begin
                rem <= trial[FREQ_W-1:0];
                quo <= {quo[PRODUCT_W-2:0], 1'b0};
            end
        end
    end

    // coder must wait for done before the next request
    assert property (@(posedge clk) disable iff (!rstn) div.go |-> !busy)
        else $error("divider restarted while busy");

endmodule

// ==== rtl/intervalCoder.sv ====
// encoder FSM with subinterval update, rescaling with pending bits, symbol request and termination
`timescale 1ns/100ps

module intervalCoder (
    input logic clk,
    input logic rstn,
    input logic start,
    input logic newBitsProvided,
    input codecPkg::symbol_t inputSymbol,
    output logic idle,
    output logic newBitsRequested,
    divIf.coder div,
    modelIf.coder model,
    packIf.coder pack
);
    import codecPkg::*;

    coderState_e state;
    logic [PRECISION-1:0] a;          // interval low
    logic [PRECISION-1:0] b;          // interval high
    logic [PRECISION-1:0] w;
    logic [PRODUCT_W-1:0] prodLow;    // w*freqBegin for the division after b
    logic [PENDING_W-1:0] pending;
    logic pendingBit;                 // value of the deferred bits
    logic terminating;
    logic symbolAck;                  // second phase of the symbol handshake
    symbol_t symbol;
    logic lowHalf;
    logic highHalf;
    logic middle;

    assign lowHalf = b < HALF;
    assign highHalf = a > HALF;
    assign middle = (a > QUARTER) && (b < THREE_QUARTERS);

    assign model.symbol = symbol;
    assign model.init = (state == IDLE) && start;   // table ready for the first MUL
    assign model.update = (state == UPDATE_MODEL);

    // bit stream towards the packer is held off while a word waits for the host
    always_comb begin
        pack.bitValid = 1'b0;
        pack.bitValue = 1'b0;
        pack.flush = 1'b0;
        if (!pack.full) begin
            case (state)
                RESCALE: begin
                    pack.bitValid = lowHalf || highHalf;
                    pack.bitValue = !lowHalf;
                end
                EMIT_PENDING: begin
                    pack.bitValid = 1'b1;
                    pack.bitValue = pendingBit;
                end
                TERMINATE: begin
                    pack.bitValid = !terminating;
                    pack.bitValue = a > QUARTER;
                    pack.flush = terminating;     // all bits out so the word closes
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            idle <= 1'b1;
            newBitsRequested <= 1'b0;
            terminating <= 1'b0;
            symbolAck <= 1'b0;
            div.go <= 1'b0;
        end else begin
            div.go <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        symbol <= inputSymbol;
                        a <= '0;
                        b <= WHOLE;
                        w <= WHOLE;
                        pending <= '0;
                        terminating <= 1'b0;
                        idle <= 1'b0;
                        state <= MUL;
                    end
                end
                MUL: begin
                    div.dividend <= w * model.freqEnd;
                    div.divisor <= model.total;
                    div.go <= 1'b1;
                    prodLow <= w * model.freqBegin;
                    state <= DIV_HIGH;
                end
                DIV_HIGH: begin
                    if (div.done) begin
                        b <= a + div.quotient;    // a still holds the old low
                        div.dividend <= prodLow;
                        div.go <= 1'b1;
                        state <= DIV_LOW;
                    end
                end
                DIV_LOW: begin
                    if (div.done) begin
                        a <= a + div.quotient;
                        state <= RESCALE;
                    end
                end
                RESCALE: begin
                    if (lowHalf || highHalf) begin
                        if (!pack.full) begin
                            a <= lowHalf ? (a << 1) : ((a - HALF) << 1);
                            b <= lowHalf ? (b << 1) : ((b - HALF) << 1);
                            pendingBit <= lowHalf;   // pending bits are the opposite
                            if (pending != '0) begin
                                state <= EMIT_PENDING;
                            end
                        end
                    end else if (middle) begin
                        a <= (a - QUARTER) << 1;
                        b <= (b - QUARTER) << 1;
                        pending <= pending + 1'b1;
                    end else if (symbol == EOF_SYMBOL) begin
                        state <= TERMINATE;
                    end else begin
                        newBitsRequested <= 1'b1;
                        state <= UPDATE_MODEL;
                    end
                end
                EMIT_PENDING: begin
                    if (!pack.full) begin
                        pending <= pending - 1'b1;
                        if (pending == PENDING_W'(1)) begin
                            if (terminating) begin
                                state <= TERMINATE;
                            end else begin
                                state <= RESCALE;
                            end
                        end
                    end
                end
                UPDATE_MODEL: begin
                    w <= b - a;
                    state <= REQUEST_SYMBOL;
                end
                REQUEST_SYMBOL: begin
                    if (!symbolAck) begin
                        if (newBitsProvided) begin
                            newBitsRequested <= 1'b0;
                            symbol <= inputSymbol;
                            symbolAck <= 1'b1;
                        end
                    end else if (!newBitsProvided) begin
                        symbolAck <= 1'b0;
                        state <= MUL;
                    end
                end
                TERMINATE: begin
                    if (!pack.full) begin
                        if (!terminating) begin
                            // final bit picks the quarter and at least one opposite bit follows
                            pending <= pending + 1'b1;
                            pendingBit <= (a <= QUARTER);
                            terminating <= 1'b1;
                            state <= EMIT_PENDING;
                        end else begin
                            state <= WAIT_PACKER;
                        end
                    end
                end
                WAIT_PACKER: begin
                    if (!pack.full) begin   // last word read or nothing left to send
                        idle <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // interval stays non-empty for the whole message
    assert property (@(posedge clk) disable iff (!rstn) !idle |-> a < b)
        else $error("interval low reached high");

    // deferred bits must fit the pending counter
    assert property (@(posedge clk) disable iff (!rstn)
        ((state == RESCALE && !lowHalf && !highHalf && middle) ||
         (state == TERMINATE && !terminating)) |-> pending != '1)
        else $error("pending bit counter overflow");

endmodule

// ==== rtl/bitPacker.sv ====
// packs code bits LSB first into output words, counts valid bytes, read handshake
`timescale 1ns/100ps

module bitPacker (
    input logic clk,
    input logic rstn,
    input logic readSuccess,
    output logic resultReady,
    output logic [2:0] validOutputBytes,
    output logic [codecPkg::WORD_W-1:0] out,
    packIf.packer pack
);
    import codecPkg::*;

    logic [$clog2(WORD_W)-1:0] cursor;   // next free bit
    logic readAck;                       // word taken, waiting for readSuccess to drop
    logic [2:0] flushBytes;

    // bytes touched by a partial word, rounded up
    assign flushBytes = 3'(({1'b0, cursor} + 6'd7) >> 3);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out <= '0;
            cursor <= '0;
            readAck <= 1'b0;
            resultReady <= 1'b0;
            validOutputBytes <= '0;
            pack.full <= 1'b0;
        end else begin
            if (resultReady) begin
                if (readSuccess) begin
                    resultReady <= 1'b0;
                    out <= '0;
                    cursor <= '0;
                    readAck <= 1'b1;
                end
            end else if (readAck) begin
                if (!readSuccess) begin
                    readAck <= 1'b0;
                    pack.full <= 1'b0;     // coder may continue
                end
            end else if (pack.bitValid) begin
                out[cursor] <= pack.bitValue;
                cursor <= cursor + 1'b1;
                if (cursor == WORD_W - 1) begin
                    pack.full <= 1'b1;
                    resultReady <= 1'b1;
                    validOutputBytes <= 3'd4;
                end
            end else if (pack.flush && cursor != '0) begin   // empty word is not presented
                pack.full <= 1'b1;
                resultReady <= 1'b1;
                validOutputBytes <= flushBytes;
            end
        end
    end

endmodule

// ==== rtl/arithEncoder.sv ====
// arithmetic encoder top: coder, divider, frequency model and bit packer on their buses
`timescale 1ns/100ps

module arithEncoder (
    input logic clk,
    input logic rstn,
    input logic start,
    input logic readSuccess,
    input logic newBitsProvided,
    input codecPkg::symbol_t inputSymbol,
    output logic idle,
    output logic resultReady,
    output logic newBitsRequested,
    output logic [2:0] validOutputBytes,
    output logic [codecPkg::WORD_W-1:0] out
);

    divIf divBus ();
    modelIf modelBus ();
    packIf packBus ();

    intervalCoder u_intervalCoder (
        .clk              (clk),
        .rstn             (rstn),
        .start            (start),
        .newBitsProvided  (newBitsProvided),
        .inputSymbol      (inputSymbol),
        .idle             (idle),
        .newBitsRequested (newBitsRequested),
        .div              (divBus),
        .model            (modelBus),
        .pack             (packBus)
    );

    intervalDivider u_intervalDivider (
        .clk  (clk),
        .rstn (rstn),
        .div  (divBus)
    );

    freqModel u_freqModel (
        .clk   (clk),
        .rstn  (rstn),
        .model (modelBus)
    );

    bitPacker u_bitPacker (
        .clk              (clk),
        .rstn             (rstn),
        .readSuccess      (readSuccess),
        .resultReady      (resultReady),
        .validOutputBytes (validOutputBytes),
        .out              (out),
        .pack             (packBus)
    );

endmodule

// ==== test/encoderModel.svh ====
// reference encoder: adaptive table, subinterval math, rescaling, termination and word packing
`ifndef ENCODER_MODEL_SVH
`define ENCODER_MODEL_SVH

function automatic void encodeRef(input int msg[$], output logic [WORD_W-1:0] words[$],
                                  output int lastBytes);
    longint lo;
    longint hi;
    longint width;
    longint total;
    longint cumBegin [NUM_SYMBOLS];
    longint cumEnd [NUM_SYMBOLS];
    int pend;
    int sym;
    int tail;
    logic bitVal;
    logic bits[$];
    logic [WORD_W-1:0] word;
    bit rescaling;

    // every symbol starts with the same count
    for (int k = 0; k < NUM_SYMBOLS; k++) begin
        cumBegin[k] = INIT_COUNT * k;
        cumEnd[k] = INIT_COUNT * (k + 1);
    end
    total = INIT_COUNT * NUM_SYMBOLS;
    lo = 0;
    hi = WHOLE;
    width = WHOLE;
    pend = 0;
    words.delete();

    foreach (msg[i]) begin
        sym = msg[i];
        hi = lo + width * cumEnd[sym] / total;    // both from the old low
        lo = lo + width * cumBegin[sym] / total;
        rescaling = 1'b1;
        while (rescaling) begin
            if (hi < HALF) begin
                bits.push_back(1'b0);
                repeat (pend) bits.push_back(1'b1);
                pend = 0;
                lo = 2 * lo;
                hi = 2 * hi;
            end else if (lo > HALF) begin
                bits.push_back(1'b1);
                repeat (pend) bits.push_back(1'b0);
                pend = 0;
                lo = 2 * (lo - HALF);
                hi = 2 * (hi - HALF);
            end else if (lo > QUARTER && hi < THREE_QUARTERS) begin
                pend++;    // decided later by the next outer rescale
                lo = 2 * (lo - QUARTER);
                hi = 2 * (hi - QUARTER);
            end else begin
                rescaling = 1'b0;
            end
        end
        if (sym == EOF_SYMBOL) begin
            pend++;
            bitVal = lo > QUARTER;
            bits.push_back(bitVal);
            repeat (pend) bits.push_back(!bitVal);
        end else begin
            width = hi - lo;
            for (int k = sym; k < NUM_SYMBOLS; k++) begin
                cumEnd[k]--;
                if (k > sym) begin
                    cumBegin[k]--;
                end
            end
            total--;
        end
    end

    // first code bit goes to bit 0 of the first word
    word = '0;
    foreach (bits[n]) begin
        word[n % WORD_W] = bits[n];
        if (n % WORD_W == WORD_W - 1 || n == bits.size() - 1) begin
            words.push_back(word);
            word = '0;
        end
    end
    tail = bits.size() - WORD_W * (words.size() - 1);
    lastBytes = (tail + 7) / 8;
endfunction

`endif

// ==== test/tbArithEncoder.sv ====
// testbench for the arithmetic encoder: clock, reset, host handshakes, reference compare, timeout
`timescale 1ns/100ps

module tbArithEncoder;
    import codecPkg::*;

    localparam int NUM_RANDOM = 12;
    localparam int NUM_SLOW = 2;    // each message runs once fast and once slow
    localparam int MAX_DATA = 40;
    localparam int MAX_SYMBOLS = 1 + 9 + (NUM_RANDOM + 2 * NUM_SLOW) * (MAX_DATA + 1);
    localparam int CYCLE_LIMIT = 2000 * MAX_SYMBOLS;

    logic clk = 1'b0;
    logic rstn;
    logic start;
    logic readSuccess;
    logic newBitsProvided;
    symbol_t inputSymbol;
    logic idle;
    logic resultReady;
    logic newBitsRequested;
    logic [2:0] validOutputBytes;
    logic [WORD_W-1:0] out;

    int msg[$];                      // message currently coded
    int symIdx;                      // next symbol the host hands over
    logic [WORD_W-1:0] expWords[$];
    int expLast;
    int wordIdx;
    int maxDelay = 5;                // host reaction time in cycles
    logic prevReady;
    int cycles = 0;

    `include "encoderModel.svh"

    arithEncoder u_arithEncoder (
        .clk              (clk),
        .rstn             (rstn),
        .start            (start),
        .readSuccess      (readSuccess),
        .newBitsProvided  (newBitsProvided),
        .inputSymbol      (inputSymbol),
        .idle             (idle),
        .resultReady      (resultReady),
        .newBitsRequested (newBitsRequested),
        .validOutputBytes (validOutputBytes),
        .out              (out)
    );

    always #2 clk = ~clk;

    task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic void makeMessage(output int list[$], input int len, input bit narrow);
        list.delete();
        for (int i = 0; i < len; i++) begin
            if (narrow) begin
                list.push_back($urandom_range(8, 7));    // straddles the middle, pending bits
            end else begin
                list.push_back($urandom_range(15, 0));
            end
        end
        list.push_back(EOF_SYMBOL);
    endfunction

    task automatic runMessage(input int list[$], input int delayMax);
        msg = list;
        symIdx = 1;    // first symbol goes with start
        maxDelay = delayMax;
        wordIdx = 0;
        encodeRef(list, expWords, expLast);
        @(negedge clk);
        checkValue("idle before start", idle, 1);
        inputSymbol = symbol_t'(list[0]);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        checkValue("idle after start", idle, 0);
        while (!idle) @(negedge clk);
        checkValue("words received", wordIdx, expWords.size());
        checkValue("symbols taken", symIdx, list.size());
    endtask

    // symbol host, both phases of the request handshake
    initial begin
        forever begin
            @(negedge clk);
            if (newBitsRequested) begin
                waitCycles($urandom_range(maxDelay, 0));
                checkValue("symbol request in range", symIdx < msg.size(), 1);
                inputSymbol = symbol_t'(msg[symIdx]);
                symIdx++;
                newBitsProvided = 1'b1;
                do @(negedge clk); while (newBitsRequested);
                waitCycles($urandom_range(maxDelay, 0));
                newBitsProvided = 1'b0;
            end
        end
    end

    // word reader, releases readSuccess only after resultReady dropped
    initial begin
        forever begin
            @(negedge clk);
            if (resultReady) begin
                waitCycles($urandom_range(maxDelay, 0));
                readSuccess = 1'b1;
                do @(negedge clk); while (resultReady);
                waitCycles($urandom_range(maxDelay, 0));
                readSuccess = 1'b0;
            end
        end
    end

    // compares each new word once, when resultReady rises
    always @(negedge clk) begin
        if (rstn && resultReady && !prevReady) begin
            checkValue("no extra output word", wordIdx < expWords.size(), 1);
            checkValue($sformatf("word %0d", wordIdx), out, expWords[wordIdx]);
            checkValue($sformatf("byte count of word %0d", wordIdx), validOutputBytes,
                       (wordIdx == expWords.size() - 1) ? expLast : 4);
            wordIdx++;
        end
        prevReady = resultReady;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("TIMEOUT: encoder did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $fatal(1, "run aborted");
        end
    end

    initial begin
        int list[$];

        void'($urandom(32'h1020f565));
        rstn = 1'b0;
        start = 1'b0;
        readSuccess = 1'b0;
        newBitsProvided = 1'b0;
        inputSymbol = '0;
        waitCycles(5);
        checkValue("idle after reset", idle, 1);
        checkValue("resultReady after reset", resultReady, 0);
        checkValue("newBitsRequested after reset", newBitsRequested, 0);
        checkValue("out after reset", out, 0);
        rstn = 1'b1;

        list = '{EOF_SYMBOL};    // EOF alone
        runMessage(list, 5);

        list.delete();
        repeat (8) list.push_back(0);
        list.push_back(EOF_SYMBOL);
        runMessage(list, 5);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            makeMessage(list, $urandom_range(MAX_DATA, 1), t % 2);
            runMessage(list, 5);
        end

        // same message with a quick host and with a slow one
        for (int s = 0; s < NUM_SLOW; s++) begin
            makeMessage(list, MAX_DATA, s % 2);
            runMessage(list, 0);
            runMessage(list, 40);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+test
rtl/codecPkg.sv
rtl/codecIfs.sv
rtl/freqModel.sv
rtl/intervalDivider.sv
rtl/intervalCoder.sv
rtl/bitPacker.sv
rtl/arithEncoder.sv
test/tbArithEncoder.sv

// ==== Bender.yml ====
package:
  name: arith_encoder

sources:
  - rtl/codecPkg.sv
  - rtl/codecIfs.sv
  - rtl/freqModel.sv
  - rtl/intervalDivider.sv
  - rtl/intervalCoder.sv
  - rtl/bitPacker.sv
  - rtl/arithEncoder.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tbArithEncoder.sv
